//--- hw/crossbar.sv
`timescale 1ns/1ps

module crossbar (
    input  logic                         clk,
    input  logic                         reset_i,
    input  noc_pkg::link_t               head_i [noc_pkg::PORT_NUM],
    input  noc_pkg::port_t               sel_i [noc_pkg::PORT_NUM],
    input  logic [noc_pkg::PORT_NUM-1:0] sel_valid_i,
    output noc_pkg::link_t               link_o [noc_pkg::PORT_NUM]
);

    noc_pkg::link_t link_q [noc_pkg::PORT_NUM];

    always_ff @(posedge clk)
    begin
        for (int o = 0; o < noc_pkg::PORT_NUM; o++)
        begin
            if (reset_i)
            begin
                link_q[o].valid_flit <= 1'b0;
            end
            else
            begin
                link_q[o].valid_flit <= sel_valid_i[o] && head_i[sel_i[o]].valid_flit;
            end
            link_q[o].flit <= head_i[sel_i[o]].flit;  // Payload moves without reset
        end
    end

    always_comb
    begin
        for (int o = 0; o < noc_pkg::PORT_NUM; o++)
        begin
            link_o[o] = link_q[o];
        end
    end

endmodule

//--- hw/input_port.sv
`timescale 1ns/1ps

module input_port #(
    parameter int X_CURRENT = noc_pkg::MESH_SIZE_X / 2,
    parameter int Y_CURRENT = noc_pkg::MESH_SIZE_Y / 2,
    parameter int BUFFER_SIZE = 8
)(
    input  logic           clk,
    input  logic           reset_i,
    input  noc_pkg::link_t link_i,
    input  logic           pop_i,
    output noc_pkg::link_t head_o,
    output noc_pkg::port_t req_o,
    output logic           req_valid_o,
    output logic           on_off_o,
    output logic           error_o
);

    localparam int PTR_W = $clog2(BUFFER_SIZE);
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);
    localparam logic [3:0] X_HERE = 4'(X_CURRENT);
    localparam logic [3:0] Y_HERE = 4'(Y_CURRENT);

    noc_pkg::flit_t   mem [BUFFER_SIZE];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             in_packet_q;  // Between an accepted HEAD and its TAIL
    logic             error_q;
    noc_pkg::port_t   route_q;      // Held for the body of the packet

    noc_pkg::flit_t   head_flit;
    noc_pkg::port_t   xy_route;
    logic             in_is_head;
    logic             seq_ok;
    logic             push;
    logic             pop;
    logic             empty;
    logic             full;

    assign empty = count_q == '0;
    assign full  = count_q == CNT_W'(BUFFER_SIZE);

    assign in_is_head = link_i.flit.kind == noc_pkg::HEAD ||
                        link_i.flit.kind == noc_pkg::HEADTAIL;
    assign seq_ok     = in_is_head ? !in_packet_q : in_packet_q;
    assign push       = link_i.valid_flit && seq_ok && !full;
    assign pop        = pop_i && !empty;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr_q] <= link_i.flit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            in_packet_q <= 1'b0;
            error_q     <= 1'b0;
            route_q     <= noc_pkg::LOCAL;
        end
        else
        begin
            if (push)
            begin
                wr_ptr_q    <= (wr_ptr_q == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr_q + 1'b1;
                in_packet_q <= link_i.flit.kind == noc_pkg::HEAD ||
                               link_i.flit.kind == noc_pkg::BODY;
            end
            if (pop)
            begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Out-of-sequence or overflowing flits are dropped here
            if (link_i.valid_flit && (!seq_ok || full))
            begin
                error_q <= 1'b1;
            end
            if (pop && head_flit.kind == noc_pkg::HEAD)
            begin
                route_q <= xy_route;
            end
        end
    end

    assign head_flit = mem[rd_ptr_q];

    // Dimension-ordered routing, X first
    always_comb
    begin
        if (head_flit.payload.head.dest_x > X_HERE)
        begin
            xy_route = noc_pkg::EAST;
        end
        else if (head_flit.payload.head.dest_x < X_HERE)
        begin
            xy_route = noc_pkg::WEST;
        end
        else if (head_flit.payload.head.dest_y > Y_HERE)
        begin
            xy_route = noc_pkg::NORTH;
        end
        else if (head_flit.payload.head.dest_y < Y_HERE)
        begin
            xy_route = noc_pkg::SOUTH;
        end
        else
        begin
            xy_route = noc_pkg::LOCAL;
        end
    end

    assign req_o = (head_flit.kind == noc_pkg::HEAD || head_flit.kind == noc_pkg::HEADTAIL) ?
                   xy_route : route_q;
    assign req_valid_o = !empty;  // Only well-sequenced flits are ever stored

    assign head_o.valid_flit = !empty;
    assign head_o.flit       = head_flit;

    // Two spare entries absorb the flit already in flight on the link
    assign on_off_o = count_q < CNT_W'(BUFFER_SIZE - 2);
    assign error_o  = error_q;

endmodule

//--- hw/noc_pkg.sv
package noc_pkg;

    // Mesh geometry
    parameter int MESH_SIZE_X = 4;
    parameter int MESH_SIZE_Y = 4;

    parameter int PORT_NUM = 5;

    // Order fixes the index of every per-port array
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        NORTH = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        EAST  = 3'd4
    } port_t;

    typedef enum logic [1:0] {
        HEAD     = 2'd0,
        BODY     = 2'd1,
        TAIL     = 2'd2,
        HEADTAIL = 2'd3  // Single-flit packet
    } flit_kind_t;

    typedef struct packed {
        logic [3:0] dest_x;
        logic [3:0] dest_y;
        logic [7:0] info;
    } flit_head_t;

    // HEAD and HEADTAIL carry a destination, BODY and TAIL carry data
    typedef union packed {
        flit_head_t  head;
        logic [15:0] data;
    } flit_payload_u;

    typedef struct packed {
        flit_kind_t    kind;
        flit_payload_u payload;
    } flit_t;

    typedef struct packed {
        logic  valid_flit;
        flit_t flit;
    } link_t;

endpackage

//--- hw/router.sv
`timescale 1ns/1ps

module router #(
    parameter int X_CURRENT = noc_pkg::MESH_SIZE_X / 2,
    parameter int Y_CURRENT = noc_pkg::MESH_SIZE_Y / 2,
    parameter int BUFFER_SIZE = 8
)(
    input  logic                         clk,
    input  logic                         reset_i,
    input  noc_pkg::link_t               link_i [noc_pkg::PORT_NUM],
    input  logic [noc_pkg::PORT_NUM-1:0] on_off_i,
    output noc_pkg::link_t               link_o [noc_pkg::PORT_NUM],
    output logic [noc_pkg::PORT_NUM-1:0] on_off_o,
    output logic [noc_pkg::PORT_NUM-1:0] error_o
);

    // Input ports to allocator and crossbar
    noc_pkg::link_t               head [noc_pkg::PORT_NUM];
    noc_pkg::port_t               req [noc_pkg::PORT_NUM];
    logic [noc_pkg::PORT_NUM-1:0] req_valid;
    noc_pkg::flit_kind_t          head_kind [noc_pkg::PORT_NUM];

    // Allocator to input ports and crossbar
    logic [noc_pkg::PORT_NUM-1:0] pop;
    noc_pkg::port_t               sel [noc_pkg::PORT_NUM];
    logic [noc_pkg::PORT_NUM-1:0] sel_valid;

    genvar p;
    generate
        for (p = 0; p < noc_pkg::PORT_NUM; p++)
        begin: gen_input
            input_port #(
                .X_CURRENT(X_CURRENT),
                .Y_CURRENT(Y_CURRENT),
                .BUFFER_SIZE(BUFFER_SIZE)
            )
            input_port_inst (
                .clk(clk),
                .reset_i(reset_i),
                .link_i(link_i[p]),
                .pop_i(pop[p]),
                .head_o(head[p]),
                .req_o(req[p]),
                .req_valid_o(req_valid[p]),
                .on_off_o(on_off_o[p]),
                .error_o(error_o[p])
            );

            assign head_kind[p] = head[p].flit.kind;
        end
    endgenerate

    switch_allocator switch_allocator_inst (
        .clk(clk),
        .reset_i(reset_i),
        .req_i(req),
        .req_valid_i(req_valid),
        .head_kind_i(head_kind),
        .on_off_i(on_off_i),
        .pop_o(pop),
        .sel_o(sel),
        .sel_valid_o(sel_valid)
    );

    crossbar crossbar_inst (
        .clk(clk),
        .reset_i(reset_i),
        .head_i(head),
        .sel_i(sel),
        .sel_valid_i(sel_valid),
        .link_o(link_o)
    );

endmodule

//--- hw/switch_allocator.sv
`timescale 1ns/1ps

module switch_allocator (
    input  logic                          clk,
    input  logic                          reset_i,
    input  noc_pkg::port_t                req_i [noc_pkg::PORT_NUM],
    input  logic [noc_pkg::PORT_NUM-1:0]  req_valid_i,
    input  noc_pkg::flit_kind_t           head_kind_i [noc_pkg::PORT_NUM],
    input  logic [noc_pkg::PORT_NUM-1:0]  on_off_i,
    output logic [noc_pkg::PORT_NUM-1:0]  pop_o,
    output noc_pkg::port_t                sel_o [noc_pkg::PORT_NUM],
    output logic [noc_pkg::PORT_NUM-1:0]  sel_valid_o
);

    logic [noc_pkg::PORT_NUM-1:0] lock_q;
    noc_pkg::port_t               owner_q [noc_pkg::PORT_NUM];
    noc_pkg::port_t               rr_ptr_q [noc_pkg::PORT_NUM];  // First input searched

    logic [noc_pkg::PORT_NUM-1:0] req_m [noc_pkg::PORT_NUM];     // [output][input]
    logic [noc_pkg::PORT_NUM-1:0] new_req_m [noc_pkg::PORT_NUM]; // Requests by packet heads
    logic [noc_pkg::PORT_NUM-1:0] last_flit;

    function automatic noc_pkg::port_t next_port(input noc_pkg::port_t p, input int step);
        int sum;
        sum = int'(p) + step;
        if (sum >= noc_pkg::PORT_NUM)
        begin
            sum = sum - noc_pkg::PORT_NUM;
        end
        return noc_pkg::port_t'(sum);
    endfunction

    always_comb
    begin
        for (int i = 0; i < noc_pkg::PORT_NUM; i++)
        begin
            last_flit[i] = head_kind_i[i] == noc_pkg::TAIL ||
                           head_kind_i[i] == noc_pkg::HEADTAIL;
            for (int o = 0; o < noc_pkg::PORT_NUM; o++)
            begin
                req_m[o][i]     = req_valid_i[i] && req_i[i] == noc_pkg::port_t'(o);
                new_req_m[o][i] = req_m[o][i] && (head_kind_i[i] == noc_pkg::HEAD ||
                                                  head_kind_i[i] == noc_pkg::HEADTAIL);
            end
        end
    end

    always_comb
    begin
        for (int o = 0; o < noc_pkg::PORT_NUM; o++)
        begin
            sel_o[o]       = owner_q[o];
            sel_valid_o[o] = 1'b0;
            if (on_off_i[o] && lock_q[o])
            begin
                sel_valid_o[o] = req_m[o][owner_q[o]];
            end
            else if (on_off_i[o])
            begin
                // Walked backwards so the closest input to the pointer wins
                for (int k = noc_pkg::PORT_NUM - 1; k >= 0; k--)
                begin
                    if (new_req_m[o][next_port(rr_ptr_q[o], k)])
                    begin
                        sel_o[o]       = next_port(rr_ptr_q[o], k);
                        sel_valid_o[o] = 1'b1;
                    end
                end
            end
        end
    end

    // An input routes to one output only, so at most one grant per input
    always_comb
    begin
        pop_o = '0;
        for (int o = 0; o < noc_pkg::PORT_NUM; o++)
        begin
            if (sel_valid_o[o])
            begin
                pop_o[sel_o[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            lock_q <= '0;
            for (int o = 0; o < noc_pkg::PORT_NUM; o++)
            begin
                owner_q[o]  <= noc_pkg::LOCAL;
                rr_ptr_q[o] <= noc_pkg::LOCAL;
            end
        end
        else
        begin
            for (int o = 0; o < noc_pkg::PORT_NUM; o++)
            begin
                if (sel_valid_o[o] && !lock_q[o])
                begin
                    rr_ptr_q[o] <= next_port(sel_o[o], 1);
                    owner_q[o]  <= sel_o[o];
                    lock_q[o]   <= head_kind_i[sel_o[o]] == noc_pkg::HEAD;  // Wormhole hold
                end
                else if (sel_valid_o[o] && last_flit[sel_o[o]])
                begin
                    lock_q[o] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- project.f
hw/noc_pkg.sv
hw/input_port.sv
hw/switch_allocator.sv
hw/crossbar.sv
hw/router.sv
verification/router_checker.sv
verification/router_tb.sv

//--- verification/router_checker.sv
`timescale 1ns/1ps

module router_checker (
    input logic                         clk,
    input logic                         reset_i,
    input noc_pkg::link_t               out_link_i [noc_pkg::PORT_NUM],
    input logic [noc_pkg::PORT_NUM-1:0] on_off_i,
    input logic [noc_pkg::PORT_NUM-1:0] error_i
);

    int fail_count = 0;

    genvar o;
    generate
        for (o = 0; o < noc_pkg::PORT_NUM; o++)
        begin: gen_port
            link_flow: assert property (@(posedge clk) disable iff (reset_i)
                out_link_i[o].valid_flit |-> $past(on_off_i[o]))
                else
                begin
                    fail_count++;
                    $error("link_o[%0d] valid without on_off_i high the cycle before", o);
                end

            // Crossbar register comes out of reset empty
            quiet_after_reset: assert property (@(posedge clk)
                reset_i |=> !out_link_i[o].valid_flit)
                else
                begin
                    fail_count++;
                    $error("link_o[%0d] valid right after reset", o);
                end

            error_sticky: assert property (@(posedge clk)
                (!reset_i && error_i[o]) |=> (reset_i || error_i[o]))
                else
                begin
                    fail_count++;
                    $error("error_o[%0d] fell without reset", o);
                end
        end
    endgenerate

endmodule

bind router router_checker link_checker_i (
    .clk(clk),
    .reset_i(reset_i),
    .out_link_i(link_o),
    .on_off_i(on_off_i),
    .error_i(error_o)
);

//--- verification/router_tb.sv
`timescale 1ns/1ps

module router_tb;

    localparam int X_HERE = 2;
    localparam int Y_HERE = 2;
    localparam int DEPTH = 8;
    localparam int TIMEOUT = 300;  // Cycles

    logic                         clk;
    logic                         reset_i;
    noc_pkg::link_t               link_i [noc_pkg::PORT_NUM];
    logic [noc_pkg::PORT_NUM-1:0] on_off_i;
    noc_pkg::link_t               link_o [noc_pkg::PORT_NUM];
    logic [noc_pkg::PORT_NUM-1:0] on_off_o;
    logic [noc_pkg::PORT_NUM-1:0] error_o;

    noc_pkg::flit_t send_q [noc_pkg::PORT_NUM][$];  // Per input, not yet driven
    noc_pkg::flit_t exp_q [noc_pkg::PORT_NUM][$];   // Per output, in expected order
    int             send_cycle [noc_pkg::PORT_NUM];
    int             rr_ptr [noc_pkg::PORT_NUM];     // Model of the round-robin pointers
    int             cycle;
    int             west_fill;                      // WEST FIFO fill while EAST is blocked
    int             errors;
    int             checks;

    router #(.X_CURRENT(X_HERE), .Y_CURRENT(Y_HERE), .BUFFER_SIZE(DEPTH)) dut_i (
        .clk(clk),
        .reset_i(reset_i),
        .link_i(link_i),
        .on_off_i(on_off_i),
        .link_o(link_o),
        .on_off_o(on_off_o),
        .error_o(error_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string signal, input string expected, input string actual);
        errors++;
        $display("** Error at %0t: %s expected %s, got %s", $time, signal, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("At %0t: %s", $time, what);
    endtask

    function automatic noc_pkg::flit_t make_head(input noc_pkg::flit_kind_t kind,
                                                 input int dx, input int dy, input logic [7:0] info);
        noc_pkg::flit_t f;
        f.kind = kind;
        f.payload.head.dest_x = 4'(dx);
        f.payload.head.dest_y = 4'(dy);
        f.payload.head.info = info;
        return f;
    endfunction

    function automatic noc_pkg::flit_t make_data(input noc_pkg::flit_kind_t kind,
                                                 input logic [15:0] data);
        noc_pkg::flit_t f;
        f.kind = kind;
        f.payload.data = data;
        return f;
    endfunction

    // Header flits compare by destination view, body flits by data view
    function automatic bit flits_match(input noc_pkg::flit_t a, input noc_pkg::flit_t b);
        if (a.kind != b.kind)
            return 1'b0;
        if (a.kind == noc_pkg::HEAD || a.kind == noc_pkg::HEADTAIL)
            return a.payload.head == b.payload.head;
        return a.payload.data == b.payload.data;
    endfunction

    function automatic int xy_route(input int dx, input int dy);
        if (dx > X_HERE)
            return noc_pkg::EAST;
        if (dx < X_HERE)
            return noc_pkg::WEST;
        if (dy > Y_HERE)
            return noc_pkg::NORTH;
        if (dy < Y_HERE)
            return noc_pkg::SOUTH;
        return noc_pkg::LOCAL;
    endfunction

    function automatic int rr_pick(input int ptr, input logic [noc_pkg::PORT_NUM-1:0] req);
        for (int k = 0; k < noc_pkg::PORT_NUM; k++)
            if (req[(ptr + k) % noc_pkg::PORT_NUM])
                return (ptr + k) % noc_pkg::PORT_NUM;
        return 0;
    endfunction

    // Builds one packet, queues it for sending and for the routed output
    task automatic plan_packet(input int src, input int dx, input int dy, input int len,
                               input logic [7:0] tag);
        noc_pkg::flit_t f;
        int             out;
        out = xy_route(dx, dy);
        for (int i = 0; i < len; i++)
        begin
            if (len == 1)
                f = make_head(noc_pkg::HEADTAIL, dx, dy, tag);
            else if (i == 0)
                f = make_head(noc_pkg::HEAD, dx, dy, tag);
            else
                f = make_data(i == len - 1 ? noc_pkg::TAIL : noc_pkg::BODY, 16'($urandom()));
            send_q[src].push_back(f);
            exp_q[out].push_back(f);
        end
        rr_ptr[out] = (src + 1) % noc_pkg::PORT_NUM;
    endtask

    // Input driver, honours on_off_o of the previous cycle
    initial
    begin
        cycle = 0;
        west_fill = 0;
        for (int p = 0; p < noc_pkg::PORT_NUM; p++)
            link_i[p] <= '0;
        forever
        begin
            @(posedge clk);
            cycle = cycle + 1;
            if (link_i[noc_pkg::WEST].valid_flit)
                west_fill = west_fill + 1;
            for (int p = 0; p < noc_pkg::PORT_NUM; p++)
            begin
                if (!reset_i && on_off_o[p] && send_q[p].size() > 0)
                begin
                    link_i[p] <= {1'b1, send_q[p].pop_front()};
                    send_cycle[p] = cycle;
                end
                else
                    link_i[p].valid_flit <= 1'b0;
            end
        end
    end

    always @(negedge clk)
    begin
        noc_pkg::flit_t expected;
        for (int o = 0; o < noc_pkg::PORT_NUM; o++)
        begin
            if (!reset_i && link_o[o].valid_flit)
            begin
                checks++;
                assert (exp_q[o].size() > 0)
                    else report_failure($sformatf("Flit arrived on output %0d with none expected", o));
                if (exp_q[o].size() > 0)
                begin
                    expected = exp_q[o].pop_front();
                    assert (flits_match(expected, link_o[o].flit))
                        else report_mismatch($sformatf("link_o[%0d].flit", o),
                                             $sformatf("%h", expected),
                                             $sformatf("%h", link_o[o].flit));
                end
            end
        end
    end

    task automatic wait_drained();
        int n;
        bit busy;
        n = 0;
        busy = 1'b1;
        while (busy && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
            busy = 1'b0;
            for (int p = 0; p < noc_pkg::PORT_NUM; p++)
                busy = busy || send_q[p].size() > 0 || exp_q[p].size() > 0;
        end
        if (busy)
        begin
            report_failure("Timeout while waiting for expected flits to arrive");
            for (int p = 0; p < noc_pkg::PORT_NUM; p++)
            begin
                send_q[p].delete();
                exp_q[p].delete();
            end
        end
        repeat (3) @(negedge clk);  // Room for stray flits to show up
    endtask

    task automatic send_headtails_from_local();
        int dx [5] = '{2, 2, 2, 1, 3};
        int dy [5] = '{2, 3, 1, 2, 2};
        int out;
        int n;
        for (int i = 0; i < 5; i++)
        begin
            out = xy_route(dx[i], dy[i]);
            plan_packet(noc_pkg::LOCAL, dx[i], dy[i], 1, 8'(8'h10 + i));
            n = 0;
            do
            begin
                @(negedge clk);
                n++;
            end while (!link_o[out].valid_flit && n < TIMEOUT);
            if (!link_o[out].valid_flit)
                report_failure($sformatf("Timeout waiting for a flit on output %0d", out));
            checks++;
            assert (!link_o[out].valid_flit || cycle - send_cycle[noc_pkg::LOCAL] == 2)
                else report_mismatch($sformatf("link_o[%0d] latency", out), "2",
                                     $sformatf("%0d", cycle - send_cycle[noc_pkg::LOCAL]));
            wait_drained();
        end
    endtask

    task automatic send_long_packet();
        plan_packet(noc_pkg::WEST, 3, 1, 5, 8'h20);
        wait_drained();
    endtask

    // Both inputs keep requesting, so the grant order follows the pointer model
    task automatic contend_for_local();
        int left [noc_pkg::PORT_NUM];
        int winner;
        left = '{default: 0};
        left[noc_pkg::NORTH] = 2;
        left[noc_pkg::SOUTH] = 2;
        for (int k = 0; k < 4; k++)
        begin
            winner = rr_pick(rr_ptr[noc_pkg::LOCAL], {left[4] > 0, left[3] > 0, left[2] > 0,
                                                      left[1] > 0, left[0] > 0});
            left[winner]--;
            plan_packet(winner, X_HERE, Y_HERE, 3, 8'(8'h30 + k));
        end
        wait_drained();
    endtask

    task automatic block_east_output();
        bit fell;
        fell = 1'b0;
        west_fill = 0;
        @(posedge clk);
        on_off_i[noc_pkg::EAST] <= 1'b0;
        @(negedge clk);
        for (int k = 0; k < 3; k++)
            plan_packet(noc_pkg::WEST, 3, 2, 4, 8'(8'h40 + k));
        repeat (20)
        begin
            @(negedge clk);
            checks += 2;
            fell = fell || !on_off_o[noc_pkg::WEST];
            assert (!link_o[noc_pkg::EAST].valid_flit)
                else report_mismatch("link_o[EAST].valid_flit", "0", "1");
            assert (on_off_o[noc_pkg::WEST] == (DEPTH - west_fill > 2))
                else report_mismatch("on_off_o[WEST]", $sformatf("%0d", DEPTH - west_fill > 2),
                                     $sformatf("%0d", on_off_o[noc_pkg::WEST]));
        end
        assert (fell) else report_failure("on_off_o of WEST never fell while EAST was blocked");
        @(posedge clk);
        on_off_i[noc_pkg::EAST] <= 1'b1;
        wait_drained();
    endtask

    task automatic inject_stray_body();
        int n;
        checks += 3;
        assert (error_o == '0) else report_mismatch("error_o", "00000", $sformatf("%b", error_o));
        send_q[noc_pkg::SOUTH].push_back(make_data(noc_pkg::BODY, 16'hbad0));
        n = 0;
        while (!error_o[noc_pkg::SOUTH] && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!error_o[noc_pkg::SOUTH])
            report_failure("Timeout waiting for error_o of SOUTH to rise");
        assert (error_o == 5'(1 << noc_pkg::SOUTH))
            else report_mismatch("error_o", "00100", $sformatf("%b", error_o));
        wait_drained();
        plan_packet(noc_pkg::SOUTH, 0, 2, 3, 8'h50);  // Leaves on WEST
        wait_drained();
        assert (error_o[noc_pkg::SOUTH]) else report_mismatch("error_o[SOUTH]", "1", "0");
    endtask

    initial
    begin
        void'($urandom(32'hfe7b_d36f));
        errors = 0;
        checks = 0;
        for (int o = 0; o < noc_pkg::PORT_NUM; o++)
            rr_ptr[o] = noc_pkg::LOCAL;
        reset_i = 1'b1;
        on_off_i = '1;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        send_headtails_from_local();
        send_long_packet();
        contend_for_local();
        block_east_output();
        inject_stray_body();
        errors += dut_i.link_checker_i.fail_count;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
